// File: verilog/dcache_cfg.svh
// cache geometry shared by the rtl and the testbench
// the word select logic assumes a line of exactly two 64-bit words
// the index width includes the byte offset within the line
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// associativity of the data array
`define DCACHE_SET_ASSOC    4
// index bits, byte offset included
`define DCACHE_INDEX_WIDTH  12
// tag bits above the index
`define DCACHE_TAG_WIDTH    44
// one cache line
`define DCACHE_LINE_WIDTH   128
// one core word
`define DCACHE_WORD_WIDTH   64
// index bit that picks the word inside the line
`define DCACHE_WORD_SEL_BIT 3

`endif

// File: verilog/dcache_pkg.sv
// types of the data cache request controller
// line and byte-enable layouts match the array port
`include "dcache_cfg.svh"

package dcache_pkg;

    // one way of the array: payload plus state bits
    typedef struct packed {
        logic [`DCACHE_LINE_WIDTH-1:0] data;
        logic                          valid;
        logic                          dirty;
    } cache_line_t;

    // write enables of one array access
    // vldrty enables the valid and dirty bits per way
    typedef struct packed {
        logic [`DCACHE_LINE_WIDTH/8-1:0] data;
        logic [`DCACHE_SET_ASSOC-1:0]    vldrty;
    } cl_be_t;

    // source of the response word
    typedef enum logic [1:0] {
        HIT,
        CRITICAL,
        BYPASS
    } word_sel_e;

    // request controller states
    typedef enum logic [2:0] {
        IDLE,
        WAIT_TAG,
        STORE_REQ,
        WAIT_REFILL_GNT,
        WAIT_CRITICAL_WORD,
        WAIT_REFILL_VALID
    } dcache_state_e;

endpackage

// File: verilog/dcache_fsm.sv
// control fsm of the request controller
// hit, miss, bypass and write decisions are all made here
`timescale 1ns/1ps

module dcache_fsm (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  bypass_i,
    input  logic                  data_req_i,
    input  logic                  data_we_i,
    input  logic                  gnt_i,
    input  logic                  hit_i,
    input  logic                  we_q_i,
    input  logic                  miss_gnt_i,
    input  logic                  bypass_gnt_i,
    input  logic                  critical_word_valid_i,
    input  logic                  bypass_valid_i,
    output logic                  busy_o,
    output logic                  data_gnt_o,
    output logic                  data_rvalid_o,
    output logic                  capture_o,
    output logic                  bypass_set_o,
    output logic                  addr_saved_o,
    output logic                  array_req_o,
    output logic                  array_we_o,
    output logic                  save_hit_way_o,
    output logic                  miss_valid_o,
    output dcache_pkg::word_sel_e word_sel_o
);
    import dcache_pkg::*;

    dcache_state_e state_d, state_q;

    assign busy_o       = (state_q != IDLE);
    // the latched bypass flag simply follows the mode input
    assign bypass_set_o = bypass_i;

    // response word source only depends on where the data comes from
    always_comb begin
        case (state_q)
            WAIT_CRITICAL_WORD: word_sel_o = CRITICAL;
            WAIT_REFILL_VALID:  word_sel_o = BYPASS;
            default:            word_sel_o = HIT;
        endcase
    end

    // ------------------------------------------------------------------------
    // next state and strobes
    // ------------------------------------------------------------------------
    always_comb begin
        state_d        = state_q;
        data_gnt_o     = 1'b0;
        data_rvalid_o  = 1'b0;
        capture_o      = 1'b0;
        addr_saved_o   = 1'b0;
        array_req_o    = 1'b0;
        array_we_o     = 1'b0;
        save_hit_way_o = 1'b0;
        miss_valid_o   = 1'b0;

        case (state_q)
            IDLE: begin
                if (data_req_i && bypass_i) begin
                    // uncached: loads are granted right away, stores wait for the bypass
                    capture_o  = 1'b1;
                    data_gnt_o = ~data_we_i;
                    state_d    = WAIT_REFILL_GNT;
                end else if (data_req_i) begin
                    // speculative line read with the live index
                    array_req_o = 1'b1;
                    if (gnt_i) begin
                        capture_o  = 1'b1;
                        data_gnt_o = ~data_we_i;
                        state_d    = WAIT_TAG;
                    end
                end
            end

            // array data and hit vector are valid in this cycle
            WAIT_TAG: begin
                if (!hit_i) begin
                    state_d = WAIT_REFILL_GNT;
                end else if (we_q_i) begin
                    // store hit: keep the way, write in a second pass
                    save_hit_way_o = 1'b1;
                    state_d        = STORE_REQ;
                end else begin
                    data_rvalid_o = 1'b1;
                    state_d       = IDLE;
                    // overlap the next request with this response
                    if (data_req_i && !bypass_i) begin
                        array_req_o = 1'b1;
                        if (gnt_i) begin
                            capture_o  = 1'b1;
                            data_gnt_o = ~data_we_i;
                            state_d    = WAIT_TAG;
                        end
                    end
                end
            end

            // masked write into the saved hit way
            STORE_REQ: begin
                array_req_o  = 1'b1;
                array_we_o   = 1'b1;
                addr_saved_o = 1'b1;
                if (gnt_i) begin
                    data_gnt_o = 1'b1;
                    state_d    = IDLE;
                end
            end

            WAIT_REFILL_GNT: begin
                miss_valid_o = 1'b1;
                if (bypass_gnt_i) begin
                    // a bypassed store is done once the bypass path takes it
                    data_gnt_o = we_q_i;
                    state_d    = we_q_i ? IDLE : WAIT_REFILL_VALID;
                end else if (miss_gnt_i) begin
                    data_gnt_o = we_q_i;
                    state_d    = we_q_i ? IDLE : WAIT_CRITICAL_WORD;
                end
            end

            WAIT_CRITICAL_WORD: begin
                // start the next line read while the refill is in flight
                array_req_o = data_req_i & ~bypass_i;
                if (critical_word_valid_i) begin
                    data_rvalid_o = 1'b1;
                    state_d       = IDLE;
                    if (data_req_i && !bypass_i && gnt_i) begin
                        capture_o  = 1'b1;
                        data_gnt_o = ~data_we_i;
                        state_d    = WAIT_TAG;
                    end
                end
            end

            WAIT_REFILL_VALID: begin
                if (bypass_valid_i) begin
                    data_rvalid_o = 1'b1;
                    state_d       = IDLE;
                end
            end

            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

// File: verilog/req_latch.sv
// holds the accepted request for the rest of its life in the controller
// the array address is live in idle and stored during the store write
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module req_latch (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    input  logic                            capture_i,
    input  logic                            bypass_set_i,
    input  logic                            addr_saved_i,
    input  logic [`DCACHE_INDEX_WIDTH-1:0]  address_index_i,
    input  logic [`DCACHE_TAG_WIDTH-1:0]    address_tag_i,
    input  logic [7:0]                      data_be_i,
    input  logic [1:0]                      data_size_i,
    input  logic                            data_we_i,
    input  logic [`DCACHE_WORD_WIDTH-1:0]   data_wdata_i,
    output logic [`DCACHE_INDEX_WIDTH-1:0]  index_o,
    output logic [`DCACHE_TAG_WIDTH-1:0]    tag_o,
    output logic [7:0]                      be_o,
    output logic [1:0]                      size_o,
    output logic                            we_o,
    output logic [`DCACHE_WORD_WIDTH-1:0]   wdata_o,
    output logic                            bypass_o,
    output logic [`DCACHE_INDEX_WIDTH-1:0]  addr_o
);

    // request kind
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            we_o     <= 1'b0;
            bypass_o <= 1'b0;
        end else if (capture_i) begin
            we_o     <= data_we_i;
            bypass_o <= bypass_set_i;
        end
    end

    // request payload
    always_ff @(posedge clk_i) begin
        if (capture_i) begin
            index_o <= address_index_i;
            tag_o   <= address_tag_i;
            be_o    <= data_be_i;
            size_o  <= data_size_i;
            wdata_o <= data_wdata_i;
        end
    end

    assign addr_o = addr_saved_i ? index_o : address_index_i;

endmodule

// File: verilog/hit_read_path.sv
// read data path for hits, refills and bypassed loads
// hit_way_i is one-hot, all zero on a miss
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module hit_read_path (
    input  dcache_pkg::cache_line_t [`DCACHE_SET_ASSOC-1:0] data_i,
    input  logic [`DCACHE_SET_ASSOC-1:0]                    hit_way_i,
    input  logic [`DCACHE_INDEX_WIDTH-1:0]                  index_i,
    input  dcache_pkg::word_sel_e                           word_sel_i,
    input  logic [`DCACHE_WORD_WIDTH-1:0]                   critical_word_i,
    input  logic [`DCACHE_WORD_WIDTH-1:0]                   bypass_data_i,
    output logic                                            hit_o,
    output logic [`DCACHE_WORD_WIDTH-1:0]                   data_rdata_o
);
    import dcache_pkg::*;

    localparam int unsigned WordOffW = $clog2(`DCACHE_LINE_WIDTH / `DCACHE_WORD_WIDTH);

    logic [`DCACHE_LINE_WIDTH-1:0] hit_line;
    logic [`DCACHE_WORD_WIDTH-1:0] hit_word;
    logic [WordOffW-1:0]           word_off;

    assign hit_o    = |hit_way_i;
    assign word_off = index_i[`DCACHE_WORD_SEL_BIT +: WordOffW];

    // or-reduce the selected way, nothing is picked on a miss
    always_comb begin
        hit_line = '0;
        for (int unsigned w = 0; w < `DCACHE_SET_ASSOC; w++) begin
            if (hit_way_i[w]) hit_line = hit_line | data_i[w].data;
        end
    end

    assign hit_word = hit_line[word_off*`DCACHE_WORD_WIDTH +: `DCACHE_WORD_WIDTH];

    always_comb begin
        case (word_sel_i)
            CRITICAL: data_rdata_o = critical_word_i;
            BYPASS:   data_rdata_o = bypass_data_i;
            default:  data_rdata_o = hit_word;
        endcase
    end

endmodule

// File: verilog/store_merge.sv
// array request and write data for the controller
// a write touches the saved hit way only and marks it valid and dirty
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module store_merge (
    input  logic                             clk_i,
    input  logic                             rst_ni,
    input  logic                             save_hit_way_i,
    input  logic [`DCACHE_SET_ASSOC-1:0]     hit_way_i,
    input  logic                             array_req_i,
    input  logic                             array_we_i,
    input  logic [`DCACHE_INDEX_WIDTH-1:0]   index_i,
    input  logic [7:0]                       be_i,
    input  logic [`DCACHE_WORD_WIDTH-1:0]    wdata_i,
    output logic [`DCACHE_SET_ASSOC-1:0]     req_o,
    output logic                             we_o,
    output dcache_pkg::cache_line_t          data_o,
    output dcache_pkg::cl_be_t               be_o
);
    import dcache_pkg::*;

    localparam int unsigned WordOffW = $clog2(`DCACHE_LINE_WIDTH / `DCACHE_WORD_WIDTH);
    localparam int unsigned WordBytes = `DCACHE_WORD_WIDTH / 8;

    logic [`DCACHE_SET_ASSOC-1:0] hit_way_q;
    logic [WordOffW-1:0]          word_off;

    // way of the pending store
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            hit_way_q <= '0;
        end else if (save_hit_way_i) begin
            hit_way_q <= hit_way_i;
        end
    end

    assign word_off = index_i[`DCACHE_WORD_SEL_BIT +: WordOffW];
    assign we_o     = array_we_i;

    always_comb begin
        data_o = '0;
        be_o   = '0;
        // reads look up every way
        req_o  = array_req_i ? (array_we_i ? hit_way_q : '1) : '0;
        if (array_we_i) begin
            data_o.data[word_off*`DCACHE_WORD_WIDTH +: `DCACHE_WORD_WIDTH] = wdata_i;
            be_o.data[word_off*WordBytes +: WordBytes] = be_i;
            data_o.valid = 1'b1;
            data_o.dirty = 1'b1;
            be_o.vldrty  = hit_way_q;
        end
    end

endmodule

// File: verilog/dcache_ctrl_top.sv
// request controller of a four-way write-back data cache
// the tag must arrive together with the request
// one request is served at a time, except for back-to-back load hits
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_ctrl_top (
    input  logic                                              clk_i,
    input  logic                                              rst_ni,
    input  logic                                              bypass_i,
    output logic                                              busy_o,
    // core request
    input  logic                                              data_req_i,
    input  logic [`DCACHE_INDEX_WIDTH-1:0]                    address_index_i,
    input  logic [`DCACHE_TAG_WIDTH-1:0]                      address_tag_i,
    input  logic [7:0]                                        data_be_i,
    input  logic [1:0]                                        data_size_i,
    input  logic                                              data_we_i,
    input  logic [`DCACHE_WORD_WIDTH-1:0]                     data_wdata_i,
    // core response
    output logic                                              data_gnt_o,
    output logic                                              data_rvalid_o,
    output logic [`DCACHE_WORD_WIDTH-1:0]                     data_rdata_o,
    // sram array
    output logic [`DCACHE_SET_ASSOC-1:0]                      req_o,
    output logic [`DCACHE_INDEX_WIDTH-1:0]                    addr_o,
    input  logic                                              gnt_i,
    output dcache_pkg::cache_line_t                           data_o,
    output dcache_pkg::cl_be_t                                be_o,
    output logic [`DCACHE_TAG_WIDTH-1:0]                      tag_o,
    output logic                                              we_o,
    input  dcache_pkg::cache_line_t [`DCACHE_SET_ASSOC-1:0]   data_i,
    input  logic [`DCACHE_SET_ASSOC-1:0]                      hit_way_i,
    // miss unit
    output logic                                              miss_valid_o,
    output logic                                              miss_bypass_o,
    output logic [`DCACHE_TAG_WIDTH+`DCACHE_INDEX_WIDTH-1:0]  miss_addr_o,
    output logic [7:0]                                        miss_be_o,
    output logic [1:0]                                        miss_size_o,
    output logic                                              miss_we_o,
    output logic [`DCACHE_WORD_WIDTH-1:0]                     miss_wdata_o,
    input  logic                                              miss_gnt_i,
    input  logic [`DCACHE_WORD_WIDTH-1:0]                     critical_word_i,
    input  logic                                              critical_word_valid_i,
    // bypass path
    input  logic                                              bypass_gnt_i,
    input  logic                                              bypass_valid_i,
    input  logic [`DCACHE_WORD_WIDTH-1:0]                     bypass_data_i
);
    import dcache_pkg::*;

    // strobes from the fsm
    logic      capture, bypass_set, addr_saved;
    logic      array_req, array_we, save_hit_way;
    word_sel_e word_sel;

    // stored request
    logic [`DCACHE_INDEX_WIDTH-1:0] index_q;
    logic                           we_q;
    logic                           hit;

    // miss request is formed from the stored fields
    assign miss_addr_o = {tag_o, index_q};
    assign miss_we_o   = we_q;

    dcache_fsm i_fsm (
        .clk_i, .rst_ni, .bypass_i, .data_req_i, .data_we_i, .gnt_i,
        .hit_i (hit), .we_q_i (we_q), .miss_gnt_i, .bypass_gnt_i,
        .critical_word_valid_i, .bypass_valid_i, .busy_o, .data_gnt_o, .data_rvalid_o,
        .capture_o (capture), .bypass_set_o (bypass_set), .addr_saved_o (addr_saved),
        .array_req_o (array_req), .array_we_o (array_we), .save_hit_way_o (save_hit_way),
        .miss_valid_o, .word_sel_o (word_sel)
    );

    req_latch i_req_latch (
        .clk_i, .rst_ni, .capture_i (capture), .bypass_set_i (bypass_set),
        .addr_saved_i (addr_saved), .address_index_i, .address_tag_i, .data_be_i,
        .data_size_i, .data_we_i, .data_wdata_i, .index_o (index_q), .tag_o (tag_o),
        .be_o (miss_be_o), .size_o (miss_size_o), .we_o (we_q), .wdata_o (miss_wdata_o),
        .bypass_o (miss_bypass_o), .addr_o (addr_o)
    );

    hit_read_path i_hit_read_path (
        .data_i, .hit_way_i, .index_i (index_q), .word_sel_i (word_sel),
        .critical_word_i, .bypass_data_i, .hit_o (hit), .data_rdata_o
    );

    store_merge i_store_merge (
        .clk_i, .rst_ni, .save_hit_way_i (save_hit_way), .hit_way_i,
        .array_req_i (array_req), .array_we_i (array_we), .index_i (index_q),
        .be_i (miss_be_o), .wdata_i (miss_wdata_o), .req_o, .we_o, .data_o, .be_o
    );

endmodule

// File: verification/dcache_ctrl_tb.sv
// table-driven testbench for the data cache request controller
// the array model holds 256 sets of four ways and is preloaded during reset
// the miss unit never refills the array, so a missed line keeps missing
// the index layout assumes 12 bits: set, word select and byte offset
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_ctrl_tb;
    import dcache_pkg::*;

    // one table entry, expected read data included
    typedef struct packed {
        logic                           we;
        logic                           byp;
        logic                           hit;
        logic [`DCACHE_INDEX_WIDTH-1:0] index;
        logic [`DCACHE_TAG_WIDTH-1:0]   tag;
        logic [7:0]                     be;
        logic [1:0]                     size;
        logic [`DCACHE_WORD_WIDTH-1:0]  wdata;
        logic [`DCACHE_WORD_WIDTH-1:0]  exp_rdata;
    } row_t;

    // one outstanding load response
    typedef struct packed {
        logic [`DCACHE_WORD_WIDTH-1:0] data;
        word_sel_e                     src;
        logic [31:0]                   gnt_cycle;
    } resp_t;

    logic clk_i;
    logic rst_ni;
    logic bypass_i;
    logic busy_o;
    logic data_req_i;
    logic [`DCACHE_INDEX_WIDTH-1:0] address_index_i;
    logic [`DCACHE_TAG_WIDTH-1:0] address_tag_i;
    logic [7:0] data_be_i;
    logic [1:0] data_size_i;
    logic data_we_i;
    logic [`DCACHE_WORD_WIDTH-1:0] data_wdata_i;
    logic data_gnt_o;
    logic data_rvalid_o;
    logic [`DCACHE_WORD_WIDTH-1:0] data_rdata_o;
    logic [`DCACHE_SET_ASSOC-1:0] req_o;
    logic [`DCACHE_INDEX_WIDTH-1:0] addr_o;
    logic gnt_i = 1'b0;
    cache_line_t data_o;
    cl_be_t be_o;
    logic [`DCACHE_TAG_WIDTH-1:0] tag_o;
    logic we_o;
    cache_line_t [`DCACHE_SET_ASSOC-1:0] data_i;
    logic [`DCACHE_SET_ASSOC-1:0] hit_way_i;
    logic miss_valid_o;
    logic miss_bypass_o;
    logic [`DCACHE_TAG_WIDTH+`DCACHE_INDEX_WIDTH-1:0] miss_addr_o;
    logic [7:0] miss_be_o;
    logic [1:0] miss_size_o;
    logic miss_we_o;
    logic [`DCACHE_WORD_WIDTH-1:0] miss_wdata_o;
    logic miss_gnt_i = 1'b0;
    logic [`DCACHE_WORD_WIDTH-1:0] critical_word_i = '0;
    logic critical_word_valid_i = 1'b0;
    logic bypass_gnt_i = 1'b0;
    logic bypass_valid_i = 1'b0;
    logic [`DCACHE_WORD_WIDTH-1:0] bypass_data_i = '0;

    row_t  rows[$];
    row_t  miss_q[$];
    resp_t exp_q[$];
    resp_t resp;
    row_t  cur_row;
    logic [`DCACHE_WORD_WIDTH-1:0] shadow[int];
    int unsigned checks = 0;
    int unsigned errors = 0;
    int unsigned store_hits = 0;
    int unsigned writes = 0;
    int unsigned cycle_cnt = 0;
    int unsigned cycle_limit = 100000;

    // array model state
    logic [`DCACHE_TAG_WIDTH-1:0] tag_mem [0:255][0:3];
    cache_line_t                  line_mem [0:255][0:3];
    logic [7:0]                   rd_set_q;

    // miss unit and bypass model state
    int unsigned mu_phase = 0;
    int unsigned mu_delay = 0;
    logic        mu_byp;
    logic [`DCACHE_TAG_WIDTH+`DCACHE_INDEX_WIDTH-1:0] mu_addr;

    dcache_ctrl_top UUT (.*);

    always #5 clk_i = ~clk_i;

    // ------------------------------------------------------------------------
    // reference rules
    // ------------------------------------------------------------------------
    function automatic logic [63:0] pattern_word(input int set, input int way, input int word);
        return {8'(set), 4'(way), 4'(word), 16'hbeef, 8'(set), 4'(way), 4'(word), 16'h1337};
    endfunction

    function automatic logic [43:0] preload_tag(input int set, input int way);
        return {24'h0c0ffe, 4'(way), 8'(set), 8'h5a};
    endfunction

    // never present in the array
    function automatic logic [43:0] miss_tag(input int set);
        return {24'hbad5e7, 4'h0, 8'(set), 8'ha5};
    endfunction

    function automatic logic [63:0] critical_rule(input logic [55:0] addr);
        return {8'hc1, addr};
    endfunction

    function automatic logic [63:0] bypass_rule(input logic [55:0] addr);
        return {8'hb7, addr ^ 56'h00ff00ff00ff00};
    endfunction

    function automatic logic [63:0] merge_bytes(input logic [63:0] old, input logic [63:0] wdata,
                                                input logic [7:0] be);
        logic [63:0] res;
        res = old;
        for (int b = 0; b < 8; b++) begin
            if (be[b]) res[b*8 +: 8] = wdata[b*8 +: 8];
        end
        return res;
    endfunction

    task automatic check_equal(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("** Error at time %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond === 1'b1) else begin
            errors++;
            $display("At time %0t: %s", $time, what);
        end
    endtask

    // ------------------------------------------------------------------------
    // stimulus table
    // ------------------------------------------------------------------------
    task automatic add_row(input logic we, input logic byp, input logic hit, input int set,
                           input int way, input int word, input logic [7:0] be,
                           input logic [63:0] wdata);
        row_t        r;
        int          key;
        logic [63:0] cur;
        key = set * 8 + way * 2 + word;
        cur = shadow.exists(key) ? shadow[key] : pattern_word(set, way, word);
        r.we    = we;
        r.byp   = byp;
        r.hit   = hit;
        r.index = {8'(set), 1'(word), 3'b000};
        r.tag   = hit ? preload_tag(set, way) : miss_tag(set);
        r.be    = be;
        r.size  = 2'(set + word);
        r.wdata = wdata;
        if (byp) r.exp_rdata = bypass_rule({r.tag, r.index});
        else if (!hit) r.exp_rdata = critical_rule({r.tag, r.index});
        else r.exp_rdata = cur;
        // a store hit changes what later loads of that word see
        if (we && hit && !byp) begin
            shadow[key] = merge_bytes(cur, wdata, be);
            store_hits++;
        end
        rows.push_back(r);
    endtask

    task automatic build_table();
        // we, bypass, hit, set, way, word, byte enables, write data
        add_row(0, 0, 1,   3, 0, 0, 8'hff, 64'h0);
        add_row(0, 0, 1,   3, 2, 1, 8'hff, 64'h0);
        add_row(0, 0, 1,   7, 1, 0, 8'hff, 64'h0);
        add_row(0, 0, 1,   7, 3, 1, 8'hff, 64'h0);
        add_row(1, 0, 1,   3, 2, 1, 8'h0f, 64'h1111_2222_3333_4444);
        add_row(0, 0, 1,   3, 2, 1, 8'hff, 64'h0);
        add_row(0, 0, 1,   3, 2, 0, 8'hff, 64'h0);
        add_row(0, 0, 0,   9, 0, 0, 8'hff, 64'h0);
        add_row(0, 0, 1,   9, 0, 1, 8'hff, 64'h0);
        add_row(1, 0, 0,  12, 0, 1, 8'hf0, 64'h5555_6666_7777_8888);
        add_row(0, 0, 1,  12, 3, 0, 8'hff, 64'h0);
        add_row(0, 1, 0,  20, 0, 0, 8'hff, 64'h0);
        add_row(1, 1, 0,  20, 0, 1, 8'hff, 64'h9999_aaaa_bbbb_cccc);
        add_row(1, 0, 1,  40, 1, 0, 8'h81, 64'hdead_0000_0000_00ef);
        add_row(1, 0, 1,  40, 1, 0, 8'h18, 64'h0000_00be_ad00_0000);
        add_row(0, 0, 1,  40, 1, 0, 8'hff, 64'h0);
        add_row(0, 0, 0,  41, 0, 1, 8'hff, 64'h0);
        add_row(0, 0, 1,  41, 2, 1, 8'hff, 64'h0);
        add_row(0, 1, 0,   0, 0, 1, 8'hff, 64'h0);
        add_row(0, 0, 1, 255, 3, 1, 8'hff, 64'h0);
    endtask

    // cached load hits follow at once so that they overlap with the previous response
    task automatic apply_row(input row_t r);
        int unsigned gap;
        resp_t       e;
        gap = (!r.we && !r.byp && r.hit) ? 0 : $urandom % 3;
        @(negedge clk_i);
        if (gap != 0) begin
            data_req_i = 1'b0;
            repeat (gap) @(negedge clk_i);
        end
        cur_row         = r;
        bypass_i        = r.byp;
        address_index_i = r.index;
        address_tag_i   = r.tag;
        data_be_i       = r.be;
        data_size_i     = r.size;
        data_we_i       = r.we;
        data_wdata_i    = r.wdata;
        data_req_i      = 1'b1;
        if (r.byp || !r.hit) miss_q.push_back(r);
        do begin
            @(posedge clk_i);
        end while (!data_gnt_o);
        if (r.we && r.byp) check_true(bypass_gnt_i, "bypassed store granted without bypass_gnt_i");
        else if (r.we && !r.hit) check_true(miss_gnt_i, "store miss granted without miss_gnt_i");
        if (!r.we) begin
            e.data      = r.exp_rdata;
            e.src       = r.byp ? BYPASS : (r.hit ? HIT : CRITICAL);
            e.gnt_cycle = cycle_cnt;
            exp_q.push_back(e);
        end
    endtask

    // ------------------------------------------------------------------------
    // array model
    // ------------------------------------------------------------------------
    always @(negedge clk_i) gnt_i = ($urandom % 4) != 0;

    // one-hot way whose stored tag matches the row, zero if none does
    function automatic logic [3:0] way_of(input row_t r);
        logic [3:0] oh;
        oh = '0;
        for (int w = 0; w < 4; w++) begin
            if (tag_mem[r.index[11:4]][w] == r.tag) oh[w] = 1'b1;
        end
        return oh;
    endfunction

    // line and hit vector of the last granted read
    always_comb begin
        for (int w = 0; w < 4; w++) begin
            data_i[w]    = line_mem[rd_set_q][w];
            hit_way_i[w] = line_mem[rd_set_q][w].valid && (tag_mem[rd_set_q][w] == tag_o);
        end
    end

    always @(posedge clk_i) begin
        if (!rst_ni) begin
            rd_set_q <= '0;
            for (int s = 0; s < 256; s++) begin
                for (int w = 0; w < 4; w++) begin
                    tag_mem[s][w]  <= preload_tag(s, w);
                    line_mem[s][w] <= {pattern_word(s, w, 1), pattern_word(s, w, 0), 2'b10};
                end
            end
        end else if (req_o != '0 && gnt_i && !we_o) begin
            rd_set_q <= addr_o[11:4];
        end else if (req_o != '0 && gnt_i) begin
            writes <= writes + 1;
            check_equal("req_o", 64'(req_o), 64'(way_of(cur_row)));
            check_equal("be_o.vldrty", 64'(be_o.vldrty), 64'(way_of(cur_row)));
            check_equal("addr_o", 64'(addr_o), 64'(cur_row.index));
            check_true(data_o.valid && data_o.dirty, "store write leaves valid or dirty clear");
            for (int w = 0; w < 4; w++) begin
                if (req_o[w]) begin
                    for (int b = 0; b < 16; b++) begin
                        if (be_o.data[b]) begin
                            line_mem[addr_o[11:4]][w].data[b*8 +: 8] <= data_o.data[b*8 +: 8];
                        end
                    end
                    if (be_o.vldrty[w]) begin
                        line_mem[addr_o[11:4]][w].valid <= data_o.valid;
                        line_mem[addr_o[11:4]][w].dirty <= data_o.dirty;
                    end
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // miss unit and bypass model
    // ------------------------------------------------------------------------
    task automatic check_miss_request();
        row_t r;
        if (miss_q.size() == 0) begin
            check_true(1'b0, "miss request while no miss or bypass access was pending");
        end else begin
            r = miss_q.pop_front();
            check_equal("miss_addr_o", 64'(miss_addr_o), 64'({r.tag, r.index}));
            check_equal("miss_we_o", 64'(miss_we_o), 64'(r.we));
            check_equal("miss_bypass_o", 64'(miss_bypass_o), 64'(r.byp));
            check_equal("miss_size_o", 64'(miss_size_o), 64'(r.size));
            if (r.we) begin
                check_equal("miss_wdata_o", miss_wdata_o, r.wdata);
                check_equal("miss_be_o", 64'(miss_be_o), 64'(r.be));
            end
        end
    endtask

    // phase 1 waits to grant, phase 2 waits to return the word
    always @(negedge clk_i) begin
        miss_gnt_i            = 1'b0;
        bypass_gnt_i          = 1'b0;
        critical_word_valid_i = 1'b0;
        bypass_valid_i        = 1'b0;
        if (!rst_ni) begin
            mu_phase = 0;
            mu_delay = 0;
        end else if (mu_phase == 0 && miss_valid_o) begin
            mu_delay = $urandom % 4;
            mu_phase = 1;
        end else if (mu_delay != 0) begin
            mu_delay--;
        end else if (mu_phase == 1) begin
            mu_addr = miss_addr_o;
            mu_byp  = miss_bypass_o;
            if (miss_bypass_o) bypass_gnt_i = 1'b1;
            else miss_gnt_i = 1'b1;
            check_miss_request();
            mu_delay = $urandom % 4;
            mu_phase = miss_we_o ? 0 : 2;
        end else if (mu_phase == 2) begin
            if (mu_byp) begin
                bypass_valid_i = 1'b1;
                bypass_data_i  = bypass_rule(mu_addr);
            end else begin
                critical_word_valid_i = 1'b1;
                critical_word_i       = critical_rule(mu_addr);
            end
            mu_phase = 0;
        end
    end

    // ------------------------------------------------------------------------
    // response checker and timeout
    // ------------------------------------------------------------------------
    always @(posedge clk_i) begin
        if (rst_ni && data_rvalid_o) begin
            if (exp_q.size() == 0) begin
                check_true(1'b0, "data_rvalid_o pulsed with no load outstanding");
            end else begin
                resp = exp_q.pop_front();
                check_equal("data_rdata_o", data_rdata_o, resp.data);
                case (resp.src)
                    HIT:      check_true(cycle_cnt == resp.gnt_cycle + 1, "load hit response late");
                    CRITICAL: check_true(critical_word_valid_i, "miss response without critical word");
                    default:  check_true(bypass_valid_i, "bypass response without bypass_valid_i");
                endcase
            end
        end
    end

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("Timeout after %0d cycles, the DUT stopped answering", cycle_cnt);
            $display("Checks: %0d, errors: %0d", checks, errors);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'h03f5_811b));
        clk_i           = 1'b0;
        rst_ni          = 1'b0;
        bypass_i        = 1'b0;
        data_req_i      = 1'b0;
        address_index_i = '0;
        address_tag_i   = '0;
        data_be_i       = '0;
        data_size_i     = 2'd3;
        data_we_i       = 1'b0;
        data_wdata_i    = '0;
        build_table();
        cycle_limit = rows.size() * 40 + 10;
        repeat (10) @(negedge clk_i);
        rst_ni = 1'b1;
        @(posedge clk_i);
        check_true(!busy_o && !data_gnt_o && !data_rvalid_o && req_o == '0 && !we_o
                   && !miss_valid_o, "outputs not idle after reset");
        foreach (rows[i]) apply_row(rows[i]);
        @(negedge clk_i);
        data_req_i = 1'b0;
        while (exp_q.size() != 0 || busy_o) @(posedge clk_i);
        // a few quiet cycles catch stray responses
        repeat (4) @(posedge clk_i);
        check_true(miss_q.size() == 0, "expected miss or bypass requests never appeared");
        check_equal("array write count", 64'(writes), 64'(store_hits));
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+verilog
verilog/dcache_pkg.sv
verilog/dcache_fsm.sv
verilog/req_latch.sv
verilog/hit_read_path.sv
verilog/store_merge.sv
verilog/dcache_ctrl_top.sv
verification/dcache_ctrl_tb.sv
